//--- mem_bridge_defines.svh
`ifndef MEM_BRIDGE_DEFINES_SVH
`define MEM_BRIDGE_DEFINES_SVH

// byte address into the shared memory
`define ADDR_WIDTH 32

// one cache word
`define DATA_WIDTH 32

// a block is a group of consecutive words
`define BLOCK_WORDS 4
`define BLOCK_WIDTH 128

// beat counter covers one block
`define BEAT_IDX_WIDTH 2

// one strobe bit per data byte
`define STRB_WIDTH 4

`endif

//--- mem_bridge_pkg.sv
package mem_bridge_pkg;

    // data cache request, held for one clock
    typedef enum logic [2:0] {
        DC_NONE        = 3'd0,
        DC_LOAD_WORD   = 3'd1,
        DC_LOAD_BLOCK  = 3'd2,
        DC_STORE_WORD  = 3'd3,
        DC_STORE_BLOCK = 3'd4
    } dcache_req_e;

    // instruction cache only reads
    typedef enum logic [1:0] {
        IC_NONE       = 2'd0,
        IC_LOAD_WORD  = 2'd1,
        IC_LOAD_BLOCK = 2'd2
    } icache_req_e;

    typedef enum logic [2:0] {
        BUS_NONE        = 3'd0,
        BUS_READ_WORD   = 3'd1,
        BUS_READ_BLOCK  = 3'd2,
        BUS_WRITE_WORD  = 3'd3,
        BUS_WRITE_BLOCK = 3'd4
    } bus_op_e;

    typedef enum logic [1:0] {
        RESP_NONE      = 2'd0,
        RESP_DATA_DONE = 2'd1,
        RESP_INST_DONE = 2'd2
    } cache_resp_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_D_BUSY   = 3'd1,
        ST_I_BUSY   = 3'd2,
        ST_D_FINISH = 3'd3,
        ST_I_FINISH = 3'd4
    } bridge_state_e;

    // phases of one APB beat
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

endpackage

//--- req_capture.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module req_capture import mem_bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  dcache_req_e            dcache_req,
    input  logic [`ADDR_WIDTH-1:0] dcache_addr,
    input  icache_req_e            icache_req,
    input  logic [`ADDR_WIDTH-1:0] icache_addr,
    input  logic                   d_clear,
    input  logic                   i_clear,
    output logic                   d_pending,
    output dcache_req_e            d_op,
    output logic [`ADDR_WIDTH-1:0] d_addr,
    output logic                   i_pending,
    output icache_req_e            i_op,
    output logic [`ADDR_WIDTH-1:0] i_addr
);

    // data cache request slot
    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_op <= DC_NONE;
        end else if (dcache_req != DC_NONE) begin
            d_op <= dcache_req;
        end else if (d_clear) begin
            d_op <= DC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (dcache_req != DC_NONE) begin
            d_addr <= dcache_addr;
        end
    end

    // instruction cache request slot
    always_ff @(posedge clk) begin
        if (!rstn) begin
            i_op <= IC_NONE;
        end else if (icache_req != IC_NONE) begin
            i_op <= icache_req;
        end else if (i_clear) begin
            i_op <= IC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req != IC_NONE) begin
            i_addr <= icache_addr;
        end
    end

    assign d_pending = (d_op != DC_NONE);
    assign i_pending = (i_op != IC_NONE);

    // a cache waits for its response before asking again
    a_d_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        (dcache_req != DC_NONE) |-> !d_pending);
    a_i_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        (icache_req != IC_NONE) |-> !i_pending);

endmodule

//--- bridge_ctrl.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module bridge_ctrl import mem_bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   d_pending,
    input  dcache_req_e            d_op,
    input  logic [`ADDR_WIDTH-1:0] d_addr,
    input  logic                   i_pending,
    input  icache_req_e            i_op,
    input  logic [`ADDR_WIDTH-1:0] i_addr,
    output logic                   d_clear,
    output logic                   i_clear,
    output logic                   bus_start,
    output bus_op_e                bus_op,
    output logic [`ADDR_WIDTH-1:0] bus_addr,
    input  logic                   bus_done,
    output cache_resp_e            response,
    output logic                   resp_block
);

    bridge_state_e cs, ns;
    bus_op_e       d_bus_op;
    bus_op_e       i_bus_op;

    // cache request to bus operation
    always_comb begin
        unique case (d_op)
            DC_LOAD_WORD:   d_bus_op = BUS_READ_WORD;
            DC_LOAD_BLOCK:  d_bus_op = BUS_READ_BLOCK;
            DC_STORE_WORD:  d_bus_op = BUS_WRITE_WORD;
            DC_STORE_BLOCK: d_bus_op = BUS_WRITE_BLOCK;
            default:        d_bus_op = BUS_NONE;
        endcase
        unique case (i_op)
            IC_LOAD_WORD:  i_bus_op = BUS_READ_WORD;
            IC_LOAD_BLOCK: i_bus_op = BUS_READ_BLOCK;
            default:       i_bus_op = BUS_NONE;
        endcase
    end

    // data cache wins when both are waiting
    always_comb begin
        ns = cs;
        unique case (cs)
            ST_IDLE: begin
                if (d_pending) begin
                    ns = ST_D_BUSY;
                end else if (i_pending) begin
                    ns = ST_I_BUSY;
                end
            end
            ST_D_BUSY: begin
                if (bus_done) begin
                    ns = ST_D_FINISH;
                end
            end
            ST_I_BUSY: begin
                if (bus_done) begin
                    ns = ST_I_FINISH;
                end
            end
            default: ns = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cs <= ST_IDLE;
            bus_start <= 1'b0;
            bus_op <= BUS_NONE;
            resp_block <= 1'b0;
        end else begin
            cs <= ns;
            bus_start <= 1'b0;
            if (cs == ST_IDLE && ns == ST_D_BUSY) begin
                bus_start <= 1'b1;
                bus_op <= d_bus_op;
                resp_block <= (d_op == DC_LOAD_BLOCK);
            end else if (cs == ST_IDLE && ns == ST_I_BUSY) begin
                bus_start <= 1'b1;
                bus_op <= i_bus_op;
                resp_block <= (i_op == IC_LOAD_BLOCK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs == ST_IDLE) begin
            bus_addr <= d_pending ? d_addr : i_addr;
        end
    end

    // response and slot clear share the finish cycle
    always_comb begin
        unique case (cs)
            ST_D_FINISH: response = RESP_DATA_DONE;
            ST_I_FINISH: response = RESP_INST_DONE;
            default:     response = RESP_NONE;
        endcase
    end

    assign d_clear = (cs == ST_D_FINISH);
    assign i_clear = (cs == ST_I_FINISH);

    a_start_on_leave_idle: assert property (@(posedge clk) disable iff (!rstn)
        bus_start |-> ($past(cs) == ST_IDLE) && (cs inside {ST_D_BUSY, ST_I_BUSY}));
    a_done_when_busy: assert property (@(posedge clk) disable iff (!rstn)
        bus_done |-> (cs inside {ST_D_BUSY, ST_I_BUSY}));

endmodule

//--- write_buffer.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module write_buffer import mem_bridge_pkg::*; (
    input  logic                      clk,
    input  dcache_req_e               dcache_req,
    input  logic [`DATA_WIDTH-1:0]    wword,
    input  logic [`STRB_WIDTH-1:0]    wstrb,
    input  logic [`BLOCK_WIDTH-1:0]   wblock,
    input  logic [`BEAT_IDX_WIDTH-1:0] beat_index,
    output logic [`DATA_WIDTH-1:0]    beat_wdata,
    output logic [`STRB_WIDTH-1:0]    strb
);

    logic [`DATA_WIDTH-1:0]  word_q;
    logic [`STRB_WIDTH-1:0]  strb_q;
    logic [`BLOCK_WIDTH-1:0] block_q;
    logic                    block_mode;

    // store payload is taken with the request itself
    always_ff @(posedge clk) begin
        if (dcache_req == DC_STORE_WORD) begin
            word_q <= wword;
            strb_q <= wstrb;
            block_mode <= 1'b0;
        end else if (dcache_req == DC_STORE_BLOCK) begin
            block_q <= wblock;
            block_mode <= 1'b1;
        end
    end

    // word i of a block sits at bits 32*i upward
    assign beat_wdata = block_mode ? block_q[beat_index*`DATA_WIDTH +: `DATA_WIDTH] : word_q;
    assign strb = block_mode ? {`STRB_WIDTH{1'b1}} : strb_q;

endmodule

//--- apb_master.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module apb_master import mem_bridge_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       bus_start,
    input  bus_op_e                    bus_op,
    input  logic [`ADDR_WIDTH-1:0]     bus_addr,
    input  logic [`DATA_WIDTH-1:0]     beat_wdata,
    input  logic [`STRB_WIDTH-1:0]     strb,
    output logic [`BEAT_IDX_WIDTH-1:0] beat_index,
    output logic                       rd_beat_valid,
    output logic [`DATA_WIDTH-1:0]     beat_rdata,
    output logic                       bus_done,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [`ADDR_WIDTH-1:0]     paddr,
    output logic [`DATA_WIDTH-1:0]     pwdata,
    output logic [`STRB_WIDTH-1:0]     pstrb,
    input  logic [`DATA_WIDTH-1:0]     prdata,
    input  logic                       pready
);

    apb_state_e                 state;
    logic [`BEAT_IDX_WIDTH-1:0] beat_cnt;
    logic                       op_write;
    logic                       op_block;
    logic [`ADDR_WIDTH-1:0]     base_addr;
    logic                       last_beat;
    logic                       beat_end;

    assign last_beat = !op_block || (beat_cnt == `BEAT_IDX_WIDTH'(`BLOCK_WORDS - 1));
    assign beat_end = (state == APB_ACCESS) && pready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= APB_IDLE;
            beat_cnt <= '0;
            op_write <= 1'b0;
            op_block <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            unique case (state)
                APB_IDLE: begin
                    if (bus_start) begin
                        state <= APB_SETUP;
                        beat_cnt <= '0;
                        op_write <= (bus_op inside {BUS_WRITE_WORD, BUS_WRITE_BLOCK});
                        op_block <= (bus_op inside {BUS_READ_BLOCK, BUS_WRITE_BLOCK});
                    end
                end
                APB_SETUP: state <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready && last_beat) begin
                        state <= APB_IDLE;
                        bus_done <= 1'b1;
                    end else if (pready) begin
                        // next beat opens with its own setup
                        beat_cnt <= beat_cnt + 1'b1;
                        state <= APB_SETUP;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == APB_IDLE && bus_start) begin
            base_addr <= {bus_addr[`ADDR_WIDTH-1:2], 2'b00};
        end
    end

    assign psel = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);
    assign pwrite = op_write;
    assign paddr = base_addr + (`ADDR_WIDTH'(beat_cnt) << 2);
    // reads carry no write data
    assign pwdata = op_write ? beat_wdata : '0;
    // APB4 wants strobes low on reads
    assign pstrb = op_write ? strb : '0;

    assign beat_index = beat_cnt;
    assign rd_beat_valid = beat_end && !op_write;
    assign beat_rdata = prdata;

    a_enable_needs_sel: assert property (@(posedge clk) disable iff (!rstn)
        penable |-> psel);
    a_stable_until_ready: assert property (@(posedge clk) disable iff (!rstn)
        (psel && !(penable && pready)) |=>
            psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata) && $stable(pstrb));

endmodule

//--- read_assemble.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module read_assemble import mem_bridge_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       rd_beat_valid,
    input  logic [`BEAT_IDX_WIDTH-1:0] beat_index,
    input  logic [`DATA_WIDTH-1:0]     beat_rdata,
    input  cache_resp_e                response,
    input  logic                       resp_block,
    output logic [`DATA_WIDTH-1:0]     rword,
    output logic [`BLOCK_WIDTH-1:0]    rblock
);

    logic [`BLOCK_WIDTH-1:0] stage;
    logic [`DATA_WIDTH-1:0]  rword_q;
    logic [`BLOCK_WIDTH-1:0] rblock_q;
    logic                    staged;
    logic                    load_now;

    always_ff @(posedge clk) begin
        if (rd_beat_valid) begin
            stage[beat_index*`DATA_WIDTH +: `DATA_WIDTH] <= beat_rdata;
        end
    end

    // set by read beats only, so a store response leaves outputs alone
    always_ff @(posedge clk) begin
        if (!rstn) begin
            staged <= 1'b0;
        end else if (response != RESP_NONE) begin
            staged <= 1'b0;
        end else if (rd_beat_valid) begin
            staged <= 1'b1;
        end
    end

    assign load_now = (response != RESP_NONE) && staged;

    always_ff @(posedge clk) begin
        if (load_now && resp_block) begin
            rblock_q <= stage;
        end
        if (load_now && !resp_block) begin
            rword_q <= stage[`DATA_WIDTH-1:0];
        end
    end

    // new data shows already in the response cycle
    assign rword = (load_now && !resp_block) ? stage[`DATA_WIDTH-1:0] : rword_q;
    assign rblock = (load_now && resp_block) ? stage : rblock_q;

endmodule

//--- mem_bridge_top.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module mem_bridge_top import mem_bridge_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  icache_req_e             icache_req,
    input  logic [`ADDR_WIDTH-1:0]  icache_addr,
    input  dcache_req_e             dcache_req,
    input  logic [`ADDR_WIDTH-1:0]  dcache_addr,
    input  logic [`DATA_WIDTH-1:0]  wword,
    input  logic [`STRB_WIDTH-1:0]  wstrb,
    input  logic [`BLOCK_WIDTH-1:0] wblock,
    output cache_resp_e             response,
    output logic [`DATA_WIDTH-1:0]  rword,
    output logic [`BLOCK_WIDTH-1:0] rblock,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`ADDR_WIDTH-1:0]  paddr,
    output logic [`DATA_WIDTH-1:0]  pwdata,
    output logic [`STRB_WIDTH-1:0]  pstrb,
    input  logic [`DATA_WIDTH-1:0]  prdata,
    input  logic                    pready
);

    logic                       d_pending, i_pending, d_clear, i_clear;
    dcache_req_e                d_op;
    icache_req_e                i_op;
    logic [`ADDR_WIDTH-1:0]     d_addr, i_addr, bus_addr;
    logic                       bus_start, bus_done, resp_block, rd_beat_valid;
    bus_op_e                    bus_op;
    logic [`BEAT_IDX_WIDTH-1:0] beat_index;
    logic [`DATA_WIDTH-1:0]     beat_wdata, beat_rdata;
    logic [`STRB_WIDTH-1:0]     strb;

    req_capture u_req_capture (
        .clk(clk), .rstn(rstn),
        .dcache_req(dcache_req), .dcache_addr(dcache_addr),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .d_clear(d_clear), .i_clear(i_clear),
        .d_pending(d_pending), .d_op(d_op), .d_addr(d_addr),
        .i_pending(i_pending), .i_op(i_op), .i_addr(i_addr)
    );

    bridge_ctrl u_bridge_ctrl (
        .clk(clk), .rstn(rstn),
        .d_pending(d_pending), .d_op(d_op), .d_addr(d_addr),
        .i_pending(i_pending), .i_op(i_op), .i_addr(i_addr),
        .d_clear(d_clear), .i_clear(i_clear),
        .bus_start(bus_start), .bus_op(bus_op), .bus_addr(bus_addr),
        .bus_done(bus_done), .response(response), .resp_block(resp_block)
    );

    write_buffer u_write_buffer (
        .clk(clk), .dcache_req(dcache_req),
        .wword(wword), .wstrb(wstrb), .wblock(wblock),
        .beat_index(beat_index), .beat_wdata(beat_wdata), .strb(strb)
    );

    apb_master u_apb_master (
        .clk(clk), .rstn(rstn),
        .bus_start(bus_start), .bus_op(bus_op), .bus_addr(bus_addr),
        .beat_wdata(beat_wdata), .strb(strb), .beat_index(beat_index),
        .rd_beat_valid(rd_beat_valid), .beat_rdata(beat_rdata), .bus_done(bus_done),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

    read_assemble u_read_assemble (
        .clk(clk), .rstn(rstn),
        .rd_beat_valid(rd_beat_valid), .beat_index(beat_index), .beat_rdata(beat_rdata),
        .response(response), .resp_block(resp_block),
        .rword(rword), .rblock(rblock)
    );

endmodule

//--- tb_mem_bridge.sv
`timescale 1ns/10ps
`include "mem_bridge_defines.svh"

module tb_mem_bridge import mem_bridge_pkg::*; ();

    localparam int RESP_TIMEOUT = 200;
    localparam int MEM_WORDS = 256;

    logic                    clk, rstn;
    icache_req_e             icache_req;
    dcache_req_e             dcache_req;
    logic [`ADDR_WIDTH-1:0]  icache_addr, dcache_addr, paddr;
    logic [`DATA_WIDTH-1:0]  wword, rword, pwdata, prdata;
    logic [`STRB_WIDTH-1:0]  wstrb, pstrb;
    logic [`BLOCK_WIDTH-1:0] wblock, rblock;
    cache_resp_e             response;
    logic                    psel, penable, pwrite, pready;

    logic [`DATA_WIDTH-1:0]  mem [MEM_WORDS];
    logic [`ADDR_WIDTH:0]    beat_log [$];
    logic [`ADDR_WIDTH-1:0]  setup_addr;
    logic [`DATA_WIDTH-1:0]  setup_wdata;
    logic [`STRB_WIDTH-1:0]  setup_strb;
    logic                    setup_write;
    integer                  seed;
    int                      wait_left, errors, n_tests, n_failed, fd, n_fields;
    bit                      timed_out, file_error;
    logic [8*256-1:0]        line;
    logic [7:0]              f_port;
    logic [15:0]             f_op;
    logic [31:0]             f_addr;
    logic [3:0]              f_strb;
    logic [127:0]            f_wdata, f_exp;

    mem_bridge_top dut (
        .clk(clk), .rstn(rstn),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .dcache_req(dcache_req), .dcache_addr(dcache_addr),
        .wword(wword), .wstrb(wstrb), .wblock(wblock),
        .response(response), .rword(rword), .rblock(rblock),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // APB completer, random wait states, address and controls held from setup
    always @(negedge clk) begin
        if (psel && !penable) begin
            setup_addr = paddr;
            setup_write = pwrite;
            setup_wdata = pwdata;
            setup_strb = pstrb;
            wait_left = $random(seed) & 3;
            pready = 1'b0;
        end else if (psel && penable) begin
            compare_value("paddr", paddr, setup_addr);
            compare_value("pwrite", pwrite, setup_write);
            compare_value("pwdata", pwdata, setup_wdata);
            compare_value("pstrb", pstrb, setup_strb);
            if (wait_left == 0) begin
                pready = 1'b1;
                beat_log.push_back({pwrite, paddr});
                for (int b = 0; b < `STRB_WIDTH; b++) begin
                    if (pwrite && pstrb[b]) begin
                        mem[paddr[9:2]][8*b +: 8] = pwdata[8*b +: 8];
                    end
                end
                prdata = mem[paddr[9:2]];
            end else begin
                wait_left--;
            end
        end else begin
            pready = 1'b0;
        end
    end

    task automatic report_test(input string name, input bit passed);
        n_tests++;
        if (!passed) begin
            n_failed++;
        end
        $display("test %0d (%s): %s", n_tests, name, passed ? "ok" : "failed");
    endtask

    // port b sends the data op and an instruction word load in one cycle
    task automatic issue_request(input logic [7:0] port, input logic [15:0] op,
                                 input logic [31:0] addr, input logic [127:0] wdata,
                                 input logic [3:0] strb);
        @(negedge clk);
        if (port == "i") begin
            icache_req = (op == "lb") ? IC_LOAD_BLOCK : IC_LOAD_WORD;
            icache_addr = addr;
        end else begin
            case (op)
                "lb": dcache_req = DC_LOAD_BLOCK;
                "sw": dcache_req = DC_STORE_WORD;
                "sb": dcache_req = DC_STORE_BLOCK;
                default: dcache_req = DC_LOAD_WORD;
            endcase
            dcache_addr = addr;
            wword = wdata[31:0];
            wstrb = strb;
            wblock = wdata;
            if (port == "b") begin
                icache_req = IC_LOAD_WORD;
                icache_addr = addr + 32'd4;
            end
        end
        @(negedge clk);
        icache_req = IC_NONE;
        dcache_req = DC_NONE;
    endtask

    task automatic wait_response(output cache_resp_e got, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        got = RESP_NONE;
        while (!ok && n < RESP_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (response != RESP_NONE) begin
                got = response;
                ok = 1'b1;
            end
        end
    endtask

    task automatic check_read_data(input logic is_block, input logic is_write,
                                   input logic [127:0] exp, input logic [31:0] old_rword,
                                   input logic [127:0] old_rblock);
        compare_value("rword", rword, (is_write || is_block) ? old_rword : exp[31:0]);
        compare_value("rblock", rblock, (is_block && !is_write) ? exp : old_rblock);
    endtask

    task automatic run_test(input logic [7:0] port, input logic [15:0] op,
                            input logic [31:0] addr, input logic [127:0] wdata,
                            input logic [3:0] strb, input logic [127:0] exp);
        int err_before, n_beats;
        logic is_block, is_write;
        logic [31:0] old_rword;
        logic [127:0] old_rblock;
        logic [32:0] exp_beat;
        cache_resp_e got;
        bit ok;
        err_before = errors;
        is_block = (op == "lb") || (op == "sb");
        is_write = (op == "sw") || (op == "sb");
        old_rword = rword;
        old_rblock = rblock;
        beat_log.delete();
        issue_request(port, op, addr, wdata, strb);
        wait_response(got, ok);
        if (ok) begin
            compare_value("response", got, (port == "i") ? RESP_INST_DONE : RESP_DATA_DONE);
            check_read_data(is_block, is_write, exp, old_rword, old_rblock);
        end
        // instruction load of a paired test is served second
        if (ok && port == "b") begin
            wait_response(got, ok);
            if (ok) begin
                compare_value("response", got, RESP_INST_DONE);
                check_read_data(1'b0, 1'b0, exp[63:32], old_rword, old_rblock);
            end
        end
        if (ok) begin
            n_beats = is_block ? `BLOCK_WORDS : ((port == "b") ? 2 : 1);
            compare_value("beat count", beat_log.size(), n_beats);
            for (int k = 0; k < n_beats && k < beat_log.size(); k++) begin
                exp_beat = (port == "b" && k == 1) ? {1'b0, addr + 32'd4}
                                                   : {is_write, addr + 4 * k};
                compare_value("beat pwrite/paddr", beat_log[k], exp_beat);
            end
        end else begin
            $display("no response from the bridge within %0d cycles", RESP_TIMEOUT);
            timed_out = 1'b1;
        end
        report_test($sformatf("%s %s %h", port, op, addr), ok && errors == err_before);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        icache_req = IC_NONE;
        dcache_req = DC_NONE;
        icache_addr = '0;
        dcache_addr = '0;
        wword = '0;
        wstrb = '0;
        wblock = '0;
        prdata = '0;
        pready = 1'b0;
        seed = 32'hfb53;
        errors = 0;
        n_tests = 0;
        n_failed = 0;
        timed_out = 1'b0;
        file_error = 1'b0;
        // each word starts out holding its own byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'ha5000000 | (i << 2);
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        // bus and response quiet before the first request
        n_fields = errors;
        repeat (6) begin
            @(negedge clk);
            compare_value("response", response, RESP_NONE);
            compare_value("psel", psel, 1'b0);
            compare_value("penable", penable, 1'b0);
        end
        report_test("idle after reset", errors == n_fields);

        fd = $fopen("mem_bridge_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_bridge_patterns.txt");
            file_error = 1'b1;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n_fields = $sscanf(line, "%s %s %h %h %h %h",
                                       f_port, f_op, f_addr, f_wdata, f_strb, f_exp);
                    if (n_fields == 6 && f_port != "#") begin
                        run_test(f_port, f_op, f_addr, f_wdata, f_strb, f_exp);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, n_tests - n_failed, n_failed, errors);
        if (n_failed == 0 && errors == 0 && !timed_out && !file_error && n_tests > 1) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- mem_bridge_patterns.txt
# port op address wdata strobes expected
# port: d data cache, i instruction cache, b data op plus instruction load word at address+4
d sw 00000010 11223344 f 0
d lw 00000010 0 0 11223344
d sw 00000014 deadbeef 5 0
d lw 00000014 0 0 a5ad00ef
d sw 00000020 99887766 8 0
d lw 00000020 0 0 99000020
d sb 00000040 cafe0003cafe0002cafe0001cafe0000 0 0
i lb 00000040 0 0 cafe0003cafe0002cafe0001cafe0000
i lw 00000080 0 0 a5000080
d lb 000000a0 0 0 a50000aca50000a8a50000a4a50000a0
b lw 00000010 0 0 a5ad00ef11223344
i lb 00000010 0 0 a500001ca5000018a5ad00ef11223344
d lw 00000048 0 0 cafe0002
d sw 00000104 0badf00d 3 0
i lw 00000104 0 0 a500f00d
d sb 00000100 13579bdf2468ace00f1e2d3c4b5a6978 0 0
d lb 00000100 0 0 13579bdf2468ace00f1e2d3c4b5a6978
i lw 0000010c 0 0 13579bdf
b sw 00000030 5555aaaa f a500003400000000
d lw 00000030 0 0 5555aaaa

//--- src.f
+incdir+.
mem_bridge_pkg.sv
req_capture.sv
bridge_ctrl.sv
write_buffer.sv
apb_master.sv
read_assemble.sv
mem_bridge_top.sv
tb_mem_bridge.sv

//--- Bender.yml
package:
  name: mem_bridge

sources:
  - include_dirs:
      - .
    files:
      - mem_bridge_pkg.sv
      - req_capture.sv
      - bridge_ctrl.sv
      - write_buffer.sv
      - apb_master.sv
      - read_assemble.sv
      - mem_bridge_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_bridge.sv
